//--- common/cad_params.svh
// ----------------------------------------------------------
// CAD convolution engine sizes
// Image and kernel geometry, pooling and datapath widths
// ----------------------------------------------------------
`ifndef CAD_PARAMS_SVH
`define CAD_PARAMS_SVH

// Image and kernel side lengths
`define CAD_IMG_DIM   8
`define CAD_KER_DIM   5

// Valid convolution output side
`define CAD_CONV_DIM  (`CAD_IMG_DIM - `CAD_KER_DIM + 1)

// Max pooling window side
`define CAD_POOL_DIM  2

// Pixel, weight and accumulator widths
`define CAD_PIX_W     8
`define CAD_ACC_W     20

`endif

//--- common/cad_data_pkg.sv
// ----------------------------------------------------------
// CAD data types
// Pixels, weights, sums and buffer addresses
// ----------------------------------------------------------
`include "cad_params.svh"

package cad_data_pkg;

  // Signed image pixel or kernel weight
  typedef logic signed [`CAD_PIX_W-1:0] pixel_t;

  // Convolution sum, also the pooled result
  typedef logic signed [`CAD_ACC_W-1:0] acc_t;

  // Five lanes, one kernel row or the image slice under it
  typedef pixel_t [`CAD_KER_DIM-1:0] pix_row_t;

  // Linear byte addresses, row-major
  typedef logic [$clog2(`CAD_IMG_DIM * `CAD_IMG_DIM)-1:0] img_addr_t;
  typedef logic [$clog2(`CAD_KER_DIM * `CAD_KER_DIM)-1:0] ker_addr_t;

endpackage

//--- common/cad_ctrl_pkg.sv
// ----------------------------------------------------------
// CAD control types
// State encodings of the loader and the sequencer
// ----------------------------------------------------------
package cad_ctrl_pkg;

  // Which matrix the incoming bytes belong to
  typedef enum logic {
    LD_IMAGE  = 1'b0,
    LD_KERNEL = 1'b1
  } load_phase_e;

  // Processing sequencer
  typedef enum logic {
    SEQ_IDLE = 1'b0,
    SEQ_RUN  = 1'b1
  } seq_state_e;

endpackage

//--- common/cad_buf_if.sv
// ----------------------------------------------------------
// Matrix buffer ports
// Write port from the loader, row read port to the MAC
// ----------------------------------------------------------
`include "cad_params.svh"

interface buf_wr_if
  import cad_data_pkg::*;
();
  logic      wr_en;
  logic      is_kernel;
  img_addr_t wr_addr;
  pixel_t    wr_data;

  modport ldr (output wr_en, is_kernel, wr_addr, wr_data);
  modport mem (input  wr_en, is_kernel, wr_addr, wr_data);
endinterface

interface buf_rd_if
  import cad_data_pkg::*;
();
  logic                             rd_en;
  logic [$clog2(`CAD_IMG_DIM)-1:0]  img_row;
  logic [$clog2(`CAD_IMG_DIM)-1:0]  img_col;
  logic [$clog2(`CAD_KER_DIM)-1:0]  ker_row;
  // Registered, valid one cycle after rd_en
  pix_row_t                         img_data;
  pix_row_t                         ker_data;

  modport seq (output rd_en, img_row, img_col, ker_row);
  modport mem (
    input  rd_en, img_row, img_col, ker_row,
    output img_data, ker_data
  );
  modport mac (input img_data, ker_data);
endinterface

//--- source/matrix_loader.sv
// ----------------------------------------------------------
// Matrix loader
// Counts stream bytes and writes image, then kernel
// ----------------------------------------------------------
`include "cad_params.svh"

module matrix_loader
  import cad_data_pkg::*;
  import cad_ctrl_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   in_valid,
  input  pixel_t matrix,
  buf_wr_if.ldr  wr,
  output logic   load_done
);

  localparam img_addr_t IMG_LAST = img_addr_t'(`CAD_IMG_DIM * `CAD_IMG_DIM - 1);
  localparam img_addr_t KER_LAST = img_addr_t'(`CAD_KER_DIM * `CAD_KER_DIM - 1);

  load_phase_e phase;
  img_addr_t   byte_cnt;
  logic        phase_last;

  // Last byte of the current matrix
  assign phase_last = (phase == LD_IMAGE) ? (byte_cnt == IMG_LAST) : (byte_cnt == KER_LAST);

  // Every valid byte is written in its own cycle
  assign wr.wr_en     = in_valid;
  assign wr.is_kernel = (phase == LD_KERNEL);
  assign wr.wr_addr   = byte_cnt;
  assign wr.wr_data   = matrix;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase     <= LD_IMAGE;
      byte_cnt  <= '0;
      load_done <= 1'b0;
    end
    else
    begin
      load_done <= in_valid && phase_last && (phase == LD_KERNEL);
      if (in_valid)
      begin
        if (phase_last)
        begin
          // Image done -> kernel, kernel done -> rewind for next set
          byte_cnt <= '0;
          phase    <= (phase == LD_IMAGE) ? LD_KERNEL : LD_IMAGE;
        end
        else
          byte_cnt <= byte_cnt + 1'b1;
      end
    end
  end

endmodule

//--- source/matrix_buffer.sv
// ----------------------------------------------------------
// Matrix buffer
// Image and kernel registers with a five-lane row read
// ----------------------------------------------------------
`include "cad_params.svh"

module matrix_buffer
  import cad_data_pkg::*;
(
  input logic   clk,
  input logic   rst_n,
  buf_wr_if.mem wr,
  buf_rd_if.mem rd
);

  pixel_t    img_mem [`CAD_IMG_DIM * `CAD_IMG_DIM];
  pixel_t    ker_mem [`CAD_KER_DIM * `CAD_KER_DIM];
  img_addr_t img_idx [`CAD_KER_DIM];
  ker_addr_t ker_idx [`CAD_KER_DIM];

  always_ff @(posedge clk)
  begin
    if (wr.wr_en)
    begin
      if (wr.is_kernel)
        ker_mem[ker_addr_t'(wr.wr_addr)] <= wr.wr_data;
      else
        img_mem[wr.wr_addr] <= wr.wr_data;
    end
  end

  // Five consecutive pixels from (row, col), one full kernel row
  always_comb
  begin
    for (int k = 0; k < `CAD_KER_DIM; k++)
    begin
      img_idx[k] = img_addr_t'(rd.img_row * `CAD_IMG_DIM + rd.img_col + k);
      ker_idx[k] = ker_addr_t'(rd.ker_row * `CAD_KER_DIM + k);
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd.img_data <= '0;
      rd.ker_data <= '0;
    end
    else if (rd.rd_en)
    begin
      for (int k = 0; k < `CAD_KER_DIM; k++)
      begin
        rd.img_data[k] <= img_mem[img_idx[k]];
        rd.ker_data[k] <= ker_mem[ker_idx[k]];
      end
    end
  end

endmodule

//--- conv/conv_sequencer.sv
// ----------------------------------------------------------
// Convolution sequencer
// Walks pool windows, positions and kernel rows,
// one row read per cycle
// ----------------------------------------------------------
`include "cad_params.svh"

module conv_sequencer
  import cad_ctrl_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  load_done,
  buf_rd_if.seq rd,
  output logic  row_valid,
  output logic  sum_last,
  output logic  pool_last
);

  localparam int WIN_LAST = (`CAD_CONV_DIM / `CAD_POOL_DIM) ** 2 - 1;
  localparam int POS_LAST = `CAD_POOL_DIM ** 2 - 1;
  localparam int KER_LAST = `CAD_KER_DIM - 1;

  seq_state_e                      state;
  logic [$clog2(WIN_LAST+1)-1:0]   win_cnt;
  logic [$clog2(POS_LAST+1)-1:0]   pos_cnt;
  logic [$clog2(`CAD_KER_DIM)-1:0] ker_cnt;
  logic                            ker_last;
  logic                            pos_last;
  logic                            win_last;

  assign ker_last = (ker_cnt == KER_LAST);
  assign pos_last = (pos_cnt == POS_LAST);
  assign win_last = (win_cnt == WIN_LAST);

  // Counter bit 1 is the row, bit 0 the column (raster order)
  assign rd.rd_en   = (state == SEQ_RUN);
  assign rd.ker_row = ker_cnt;
  assign rd.img_row = ker_cnt + {1'b0, win_cnt[1], 1'b0} + {2'b0, pos_cnt[1]};
  assign rd.img_col = {1'b0, win_cnt[0], 1'b0} + {2'b0, pos_cnt[0]};

  // ----------------------------------------------------------
  // FSM and nested counters
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= SEQ_IDLE;
      win_cnt <= '0;
      pos_cnt <= '0;
      ker_cnt <= '0;
    end
    else
    begin
      case (state)
        SEQ_IDLE:
        begin
          if (load_done)
            state <= SEQ_RUN;
        end
        SEQ_RUN:
        begin
          if (ker_last)
          begin
            ker_cnt <= '0;
            if (pos_last)
            begin
              pos_cnt <= '0;
              if (win_last)
              begin
                // Counters wrap to zero, ready for the next set
                win_cnt <= '0;
                state   <= SEQ_IDLE;
              end
              else
                win_cnt <= win_cnt + 1'b1;
            end
            else
              pos_cnt <= pos_cnt + 1'b1;
          end
          else
            ker_cnt <= ker_cnt + 1'b1;
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // Flags line up with the buffer read data
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      row_valid <= 1'b0;
      sum_last  <= 1'b0;
      pool_last <= 1'b0;
    end
    else
    begin
      row_valid <= rd.rd_en;
      sum_last  <= rd.rd_en && ker_last;
      pool_last <= rd.rd_en && ker_last && pos_last;
    end
  end

endmodule

//--- conv/conv_pool_datapath.sv
// ----------------------------------------------------------
// Convolution and pooling datapath
// Five-lane MAC, row accumulation, 2x2 signed max pool
// ----------------------------------------------------------
`include "cad_params.svh"

module conv_pool_datapath
  import cad_data_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  buf_rd_if.mac rd,
  input  logic  row_valid,
  input  logic  sum_last,
  input  logic  pool_last,
  output logic  pool_valid,
  output acc_t  pool_value
);

  acc_t row_sum;
  acc_t prod_sum;
  acc_t acc;
  acc_t conv_sum;
  acc_t run_max;
  acc_t new_max;
  logic prod_valid;
  logic prod_sum_last;
  logic prod_pool_last;
  logic first_in_win;

  // Sum of the five lane products
  always_comb
  begin
    row_sum = '0;
    for (int k = 0; k < `CAD_KER_DIM; k++)
      row_sum = row_sum + $signed(rd.img_data[k]) * $signed(rd.ker_data[k]);
  end

  // Full conv value on the last row, signed max against the window
  assign conv_sum = acc + prod_sum;
  assign new_max  = (first_in_win || conv_sum > run_max) ? conv_sum : run_max;

  // ----------------------------------------------------------
  // Product stage and pooled result
  // ----------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (row_valid)
      prod_sum <= row_sum;
    if (prod_sum_last)
      run_max <= new_max;
    if (prod_pool_last)
      pool_value <= new_max;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      prod_valid     <= 1'b0;
      prod_sum_last  <= 1'b0;
      prod_pool_last <= 1'b0;
      acc            <= '0;
      first_in_win   <= 1'b1;
      pool_valid     <= 1'b0;
    end
    else
    begin
      prod_valid     <= row_valid;
      prod_sum_last  <= row_valid && sum_last;
      prod_pool_last <= row_valid && pool_last;
      pool_valid     <= prod_pool_last;
      // Restart the accumulator after each fifth row
      if (prod_valid)
        acc <= prod_sum_last ? '0 : conv_sum;
      if (prod_sum_last)
        first_in_win <= prod_pool_last;
    end
  end

endmodule

//--- source/result_serializer.sv
// ----------------------------------------------------------
// Result serializer
// Shifts pooled results out LSB first, one bit per cycle
// ----------------------------------------------------------
`include "cad_params.svh"

module result_serializer
  import cad_data_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic pool_valid,
  input  acc_t pool_value,
  output logic out_valid,
  output logic out_value
);

  acc_t                          hold_reg;
  logic                          hold_full;
  logic [`CAD_ACC_W-1:0]         shift_reg;
  logic [$clog2(`CAD_ACC_W)-1:0] bit_cnt;
  logic                          last_bit;
  logic                          do_load;
  logic                          take_new;
  acc_t                          load_src;

  assign last_bit = (bit_cnt == `CAD_ACC_W - 1);
  // Shifter is free when idle or on its final bit
  assign do_load  = (!out_valid || last_bit) && (hold_full || pool_valid);
  assign load_src = hold_full ? hold_reg : pool_value;
  // New result waits unless it goes straight into the shifter
  assign take_new = pool_valid && !(do_load && !hold_full);

  always_ff @(posedge clk)
  begin
    if (take_new)
      hold_reg <= pool_value;
    if (do_load)
      shift_reg <= load_src >> 1;
    else
      shift_reg <= shift_reg >> 1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hold_full <= 1'b0;
      bit_cnt   <= '0;
      out_valid <= 1'b0;
      out_value <= 1'b0;
    end
    else
    begin
      if (take_new)
        hold_full <= 1'b1;
      else if (do_load)
        hold_full <= 1'b0;

      if (do_load)
      begin
        out_valid <= 1'b1;
        out_value <= load_src[0];
        bit_cnt   <= '0;
      end
      else if (out_valid && !last_bit)
      begin
        out_value <= shift_reg[0];
        bit_cnt   <= bit_cnt + 1'b1;
      end
      else
      begin
        out_valid <= 1'b0;
        out_value <= 1'b0;
      end
    end
  end

endmodule

//--- source/cad_top.sv
// ----------------------------------------------------------
// CAD convolution engine top level
// Byte stream in, 5x5 valid conv, 2x2 max pool, serial out
// ----------------------------------------------------------
module cad_top
  import cad_data_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   in_valid,
  input  pixel_t matrix,
  output logic   out_valid,
  output logic   out_value
);

  logic load_done;
  logic row_valid;
  logic sum_last;
  logic pool_last;
  logic pool_valid;
  acc_t pool_value;

  buf_wr_if wr_bus ();
  buf_rd_if rd_bus ();

  // ----------------------------------------------------------
  // Input side
  // ----------------------------------------------------------
  matrix_loader u_loader (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .matrix    (matrix),
    .wr        (wr_bus.ldr),
    .load_done (load_done)
  );

  matrix_buffer u_buffer (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr_bus.mem),
    .rd    (rd_bus.mem)
  );

  // ----------------------------------------------------------
  // Convolution and pooling
  // ----------------------------------------------------------
  conv_sequencer u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_done (load_done),
    .rd        (rd_bus.seq),
    .row_valid (row_valid),
    .sum_last  (sum_last),
    .pool_last (pool_last)
  );

  conv_pool_datapath u_dp (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd         (rd_bus.mac),
    .row_valid  (row_valid),
    .sum_last   (sum_last),
    .pool_last  (pool_last),
    .pool_valid (pool_valid),
    .pool_value (pool_value)
  );

  // Output side
  result_serializer u_ser (
    .clk        (clk),
    .rst_n      (rst_n),
    .pool_valid (pool_valid),
    .pool_value (pool_value),
    .out_valid  (out_valid),
    .out_value  (out_value)
  );

endmodule

//--- bench/cad_tb.sv
// ----------------------------------------------------------
// CAD convolution engine testbench
// Directed sets against a conv and max-pool reference model
// ----------------------------------------------------------
`include "cad_params.svh"

module cad_tb
  import cad_data_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int IMG_N      = `CAD_IMG_DIM * `CAD_IMG_DIM;
  localparam int KER_N      = `CAD_KER_DIM * `CAD_KER_DIM;
  localparam int NUM_POOL   = (`CAD_CONV_DIM / `CAD_POOL_DIM) ** 2;
  localparam int OUT_BITS   = NUM_POOL * `CAD_ACC_W;
  localparam int WAIT_LIMIT = 1000;

  logic   clk;
  logic   rst_n;
  logic   in_valid;
  pixel_t matrix;
  logic   out_valid;
  logic   out_value;

  pixel_t              img [IMG_N];
  pixel_t              ker [KER_N];
  logic [OUT_BITS-1:0] exp_bits;
  logic [OUT_BITS-1:0] got_bits;

  cad_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .matrix    (matrix),
    .out_valid (out_valid),
    .out_value (out_value)
  );

  always #50 clk = ~clk;

  // ----------------------------------------------------------
  // Failure reporting and checks
  // ----------------------------------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic compare_value(input string name, input logic [OUT_BITS-1:0] expected,
                               input logic [OUT_BITS-1:0] actual);
    if (expected !== actual)
    begin
      $display("ERR %s expected 0x%0h actual 0x%0h", name, expected, actual);
      abort_run("Output mismatch");
    end
  endtask

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  task automatic build_expected();
    int conv [`CAD_CONV_DIM][`CAD_CONV_DIM];
    int best;
    int w;
    for (int r = 0; r < `CAD_CONV_DIM; r++)
    begin
      for (int c = 0; c < `CAD_CONV_DIM; c++)
      begin
        conv[r][c] = 0;
        for (int kr = 0; kr < `CAD_KER_DIM; kr++)
          for (int kc = 0; kc < `CAD_KER_DIM; kc++)
            conv[r][c] += int'(img[(r + kr) * `CAD_IMG_DIM + c + kc]) *
                          int'(ker[kr * `CAD_KER_DIM + kc]);
      end
    end
    // Pool windows in raster order, signed max
    w = 0;
    for (int wr = 0; wr < `CAD_CONV_DIM; wr += `CAD_POOL_DIM)
    begin
      for (int wc = 0; wc < `CAD_CONV_DIM; wc += `CAD_POOL_DIM)
      begin
        best = conv[wr][wc];
        for (int pr = 0; pr < `CAD_POOL_DIM; pr++)
          for (int pc = 0; pc < `CAD_POOL_DIM; pc++)
            if (conv[wr + pr][wc + pc] > best)
              best = conv[wr + pr][wc + pc];
        exp_bits[w * `CAD_ACC_W +: `CAD_ACC_W] = best[`CAD_ACC_W-1:0];
        w++;
      end
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < IMG_N; i++)
      img[i] = pixel_t'($urandom());
    for (int i = 0; i < KER_N; i++)
      ker[i] = pixel_t'($urandom());
  endtask

  // ----------------------------------------------------------
  // Stream driver and output collector
  // ----------------------------------------------------------
  task automatic send_set(input bit with_gaps);
    int gap;
    for (int i = 0; i < IMG_N + KER_N; i++)
    begin
      if (with_gaps)
      begin
        gap = $urandom() % 4;
        in_valid = 1'b0;
        matrix   = '0;
        repeat (gap) @(negedge clk);
      end
      in_valid = 1'b1;
      matrix   = (i < IMG_N) ? img[i] : ker[i - IMG_N];
      @(negedge clk);
    end
    in_valid = 1'b0;
    matrix   = '0;
  endtask

  // Samples at the falling edge, away from the DUT's updates
  task automatic collect_output();
    int waited;
    waited = 0;
    while (!out_valid && waited < WAIT_LIMIT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!out_valid)
      abort_run("Timeout while waiting for out_valid to rise");
    for (int i = 0; i < OUT_BITS; i++)
    begin
      compare_value("out_valid", 1'b1, out_valid);
      got_bits[i] = out_value;
      @(negedge clk);
    end
    // Exactly 80 bits, then out_valid drops
    compare_value("out_valid", 1'b0, out_valid);
  endtask

  task automatic run_set(input bit with_gaps);
    send_set(with_gaps);
    collect_output();
    compare_value("out_value", exp_bits, got_bits);
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic test_idle_after_reset();
    repeat (20)
    begin
      compare_value("out_valid", 1'b0, out_valid);
      compare_value("out_value", 1'b0, out_value);
      @(negedge clk);
    end
  endtask

  task automatic test_all_ones();
    for (int i = 0; i < IMG_N; i++)
      img[i] = 8'sd1;
    for (int i = 0; i < KER_N; i++)
      ker[i] = 8'sd1;
    // Every window sums 25 ones
    for (int w = 0; w < NUM_POOL; w++)
      exp_bits[w * `CAD_ACC_W +: `CAD_ACC_W] = 20'd25;
    run_set(1'b0);
  endtask

  task automatic test_center_tap();
    int best;
    int p;
    int w;
    // Checkerboard of small positives and large negatives
    for (int r = 0; r < `CAD_IMG_DIM; r++)
      for (int c = 0; c < `CAD_IMG_DIM; c++)
        img[r * `CAD_IMG_DIM + c] = ((r + c) % 2 == 1) ? pixel_t'(r * 3 + c) :
                                                         pixel_t'(-(r * 12 + c + 20));
    for (int i = 0; i < KER_N; i++)
      ker[i] = '0;
    ker[KER_N / 2] = 8'sd1;
    // Center tap picks the interior pixel at offset 2,2
    w = 0;
    for (int wr = 0; wr < 2; wr++)
    begin
      for (int wc = 0; wc < 2; wc++)
      begin
        best = -1000;
        for (int pr = 0; pr < 2; pr++)
        begin
          for (int pc = 0; pc < 2; pc++)
          begin
            p = int'(img[(2 + 2 * wr + pr) * `CAD_IMG_DIM + 2 + 2 * wc + pc]);
            if (p > best)
              best = p;
          end
        end
        exp_bits[w * `CAD_ACC_W +: `CAD_ACC_W] = best[`CAD_ACC_W-1:0];
        w++;
      end
    end
    run_set(1'b0);
  endtask

  task automatic test_random_set();
    fill_random();
    build_expected();
    run_set(1'b0);
  endtask

  // Gapped stream, then a second set to prove the loader rewinds
  task automatic test_gapped_reload();
    fill_random();
    build_expected();
    run_set(1'b1);
    fill_random();
    build_expected();
    run_set(1'b1);
  endtask

  initial
  begin
    void'($urandom(32'h584d_920a));
    clk      = 1'b0;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    matrix   = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    test_idle_after_reset();
    test_all_ones();
    test_center_tap();
    test_random_set();
    test_gapped_reload();

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- src.f
+incdir+common
common/cad_data_pkg.sv
common/cad_ctrl_pkg.sv
common/cad_buf_if.sv
source/matrix_loader.sv
source/matrix_buffer.sv
conv/conv_sequencer.sv
conv/conv_pool_datapath.sv
source/result_serializer.sv
source/cad_top.sv
bench/cad_tb.sv
